// File: bench/tb_ref_model.svh
// Expected register write, tagged with the cycle it must show up
typedef struct {
    int        cycle;
    reg_addr_t rd;
    word_t     data;
} write_t;

write_t expect_q[$];
word_t  model_regs [32] = '{default: '0};

// Executes one instruction on the model register file
function automatic void model_execute(input word_t ins, input int issue_cycle);
    logic [5:0] op;
    logic [5:0] fn;
    logic [4:0] sh;
    reg_addr_t  dest;
    word_t      a;
    word_t      b;
    word_t      sext;
    word_t      zext;
    word_t      res;
    logic       writes;

    op     = ins[31:26];
    fn     = ins[5:0];
    sh     = ins[10:6];
    a      = model_regs[ins[25:21]];
    b      = model_regs[ins[20:16]];
    sext   = {{16{ins[15]}}, ins[15:0]};
    zext   = {16'h0000, ins[15:0]};
    dest   = ins[20:16];
    writes = 1'b1;
    res    = '0;

    case (op)
        6'h00: begin
            dest = ins[15:11];
            // Variable shifts take the amount from rs bits 4:0
            if (fn == 6'h04 || fn == 6'h06 || fn == 6'h07) begin
                sh = a[4:0];
            end
            case (fn)
                6'h00, 6'h04: res = b << sh;
                6'h02, 6'h06: res = b >> sh;
                6'h03, 6'h07: begin
                    res = b >> sh;
                    if (b[31]) begin
                        res = res | ~(32'hffff_ffff >> sh);
                    end
                end
                6'h21: res = a + b;
                6'h23: res = a - b;
                6'h24: res = a & b;
                6'h25: res = a | b;
                6'h26: res = a ^ b;
                6'h27: res = ~(a | b);
                6'h2a: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                6'h2b: res = (a < b) ? 32'd1 : 32'd0;
                default: writes = 1'b0;
            endcase
        end
        6'h09: res = a + sext;
        6'h0a: res = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
        6'h0b: res = (a < sext) ? 32'd1 : 32'd0;
        6'h0c: res = a & zext;
        6'h0d: res = a | zext;
        6'h0e: res = a ^ zext;
        6'h0f: res = {ins[15:0], 16'h0000};
        default: writes = 1'b0;
    endcase

    if (writes && dest != 5'd0) begin
        model_regs[dest] = res;
        expect_q.push_back('{issue_cycle + 2, dest, res});
    end
endfunction

// File: bench/tb_pipeline.sv
module tb_pipeline
    import isa_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic      clk;
    logic      reset;
    logic      instr_valid;
    word_t     instr;
    logic      wb_valid;
    reg_addr_t wb_rd_addr;
    word_t     wb_data;

    int        cycle = 0;
    int        timeout_limit = 1000;
    int        seed = 54;
    word_t     program_q[$];

    `include "tb_ref_model.svh"

    write_t    head;

    pipeline dut0 (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .instr_valid ( instr_valid ),
        .instr       ( instr       ),
        .wb_valid    ( wb_valid    ),
        .wb_rd_addr  ( wb_rd_addr  ),
        .wb_data     ( wb_data     )
    );

    always #50 clk = ~clk;

    function automatic word_t reg_form(input logic [5:0] fn, input reg_addr_t rs,
                                       input reg_addr_t rt, input reg_addr_t rd,
                                       input logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t imm_form(input logic [5:0] op, input reg_addr_t rs,
                                       input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    //////////////////////////////////////////////////
    // Instruction program
    //////////////////////////////////////////////////

    task automatic build_program();
        logic [5:0] alu_fn [8] = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
        word_t      value;
        word_t      pick;
        // Random start values in r1..r8 through lui/ori
        for (int i = 1; i <= 8; i++) begin
            value = $random(seed);
            program_q.push_back(imm_form(6'h0f, 5'd0, reg_addr_t'(i), value[31:16]));
            program_q.push_back(imm_form(6'h0d, reg_addr_t'(i), reg_addr_t'(i), value[15:0]));
        end
        // Random register ALU ops whose destinations overlap the sources
        for (int i = 0; i < 24; i++) begin
            pick = $random(seed);
            program_q.push_back(reg_form(alu_fn[pick[2:0]], reg_addr_t'(1 + pick[5:3]),
                reg_addr_t'(1 + pick[8:6]), reg_addr_t'(1 + pick[12:9]), 5'd0));
        end
        // Dependent chains at distance one and two
        program_q.push_back(reg_form(6'h21, 5'd1, 5'd2, 5'd16, 5'd0));
        program_q.push_back(reg_form(6'h21, 5'd16, 5'd3, 5'd17, 5'd0));
        program_q.push_back(reg_form(6'h23, 5'd16, 5'd17, 5'd18, 5'd0));
        program_q.push_back(reg_form(6'h26, 5'd18, 5'd16, 5'd19, 5'd0));
        // Immediate extension
        program_q.push_back(imm_form(6'h09, 5'd1, 5'd20, 16'h8001));
        program_q.push_back(imm_form(6'h0a, 5'd1, 5'd21, 16'hffff));
        program_q.push_back(imm_form(6'h0b, 5'd1, 5'd22, 16'hffff));
        program_q.push_back(imm_form(6'h0c, 5'd20, 5'd23, 16'h8f0f));
        program_q.push_back(imm_form(6'h0d, 5'd0, 5'd24, 16'h8000));
        program_q.push_back(imm_form(6'h0e, 5'd24, 5'd25, 16'hffff));
        program_q.push_back(imm_form(6'h0f, 5'd0, 5'd26, 16'h8765));
        // Shifts on a negative value
        program_q.push_back(imm_form(6'h0f, 5'd0, 5'd27, 16'hf0f0));
        program_q.push_back(imm_form(6'h0d, 5'd27, 5'd27, 16'h1234));
        program_q.push_back(reg_form(6'h00, 5'd0, 5'd27, 5'd28, 5'd4));
        program_q.push_back(reg_form(6'h02, 5'd0, 5'd27, 5'd29, 5'd7));
        program_q.push_back(reg_form(6'h03, 5'd0, 5'd27, 5'd30, 5'd9));
        program_q.push_back(imm_form(6'h09, 5'd0, 5'd31, 16'd37));
        program_q.push_back(reg_form(6'h04, 5'd31, 5'd27, 5'd28, 5'd0));
        program_q.push_back(reg_form(6'h06, 5'd31, 5'd27, 5'd29, 5'd0));
        program_q.push_back(reg_form(6'h07, 5'd31, 5'd27, 5'd30, 5'd0));
        // No write for $0 targets or unknown encodings
        program_q.push_back(reg_form(6'h21, 5'd1, 5'd2, 5'd0, 5'd0));
        program_q.push_back(imm_form(6'h0d, 5'd1, 5'd0, 16'h0005));
        program_q.push_back(imm_form(6'h3f, 5'd1, 5'd2, 16'h1234));
        program_q.push_back(reg_form(6'h3e, 5'd1, 5'd2, 5'd3, 5'd0));
        program_q.push_back(reg_form(6'h21, 5'd0, 5'd0, 5'd1, 5'd0));
    endtask

    always @(posedge clk) begin
        cycle++;
        if (cycle > timeout_limit) begin
            fail_now($sformatf("Timeout after %0d cycles, %0d writes still expected",
                cycle, expect_q.size()));
        end
    end

    //////////////////////////////////////////////////
    // Comparison at the falling edge where outputs are stable
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (expect_q.size() > 0 && expect_q[0].cycle == cycle) begin
            head = expect_q.pop_front();
            assert (wb_valid === 1'b1) else
                fail_now($sformatf("Expected write to r%0d at cycle %0d did not appear",
                    head.rd, cycle));
            assert (wb_rd_addr === head.rd) else
                fail_now($sformatf("FAIL t=%0t wb_rd_addr expected %0d actual %0d",
                    $time, head.rd, wb_rd_addr));
            assert (wb_data === head.data) else
                fail_now($sformatf("FAIL t=%0t wb_data expected %08h actual %08h",
                    $time, head.data, wb_data));
        end else begin
            assert (wb_valid === 1'b0) else
                fail_now($sformatf("Unexpected write to r%0d at cycle %0d",
                    wb_rd_addr, cycle));
        end
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        build_program();
        timeout_limit = 5 + program_q.size() + 4 + 20;

        repeat (5) @(posedge clk);
        #5;
        reset = 1'b0;
        // No writes may appear in these idle cycles
        repeat (3) @(posedge clk);

        foreach (program_q[i]) begin
            @(posedge clk);
            #5;
            instr_valid = 1'b1;
            instr       = program_q[i];
            model_execute(program_q[i], cycle + 1);
        end
        @(posedge clk);
        #5;
        instr_valid = 1'b0;
        instr       = '0;

        while (expect_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: common/isa_pkg.sv
package isa_pkg;

    // Basic data types
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] word_t;

    ////////////////////////////////////////////////////
    // Instruction fields
    ////////////////////////////////////////////////////

    localparam int OPCODE_LSB  = 26;
    localparam int RS_LSB      = 21;
    localparam int RT_LSB      = 16;
    localparam int RD_LSB      = 11;
    localparam int SHAMT_LSB   = 6;
    localparam int FUNCT_LSB   = 0;
    localparam int IMM_WIDTH   = 16;
    localparam int SHAMT_WIDTH = 5;

    // Primary opcodes handled by the core
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_t;

    // Function field of the special opcode
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_SLLV = 6'h04,
        FN_SRLV = 6'h06,
        FN_SRAV = 6'h07,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_t;

endpackage

// File: common/pipe_pkg.sv
package pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_NOR, ALU_SLT, ALU_SLTU, ALU_LUI
    } alu_op_t;

    typedef enum logic [1:0] {
        SHIFT_SLL, SHIFT_SRL, SHIFT_SRA
    } shift_op_t;

    // Which unit produces the execute result
    typedef enum logic {RES_ALU, RES_SHIFT} res_sel_t;

    typedef enum logic {EXT_SIGN, EXT_ZERO} imm_ext_t;

    // Control word carried from decode into execute
    typedef struct packed {
        alu_op_t   alu_op;
        shift_op_t shift_op;
        logic      b_is_imm;
        logic      shamt_from_reg;
        res_sel_t  res_sel;
    } ex_ctrl_t;

endpackage

// File: decode/decode_stage.sv
module decode_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   instr_valid,
    input  word_t                  instr,
    output reg_addr_t              rs_addr,
    output reg_addr_t              rt_addr,
    input  word_t                  rs_data,
    input  word_t                  rt_data,
    output logic                   ex_valid,
    output logic                   ex_reg_w,
    output ex_ctrl_t               ex_ctrl,
    output reg_addr_t              ex_rs_addr,
    output reg_addr_t              ex_rt_addr,
    output reg_addr_t              ex_rd_addr,
    output word_t                  ex_op_a,
    output word_t                  ex_op_b,
    output word_t                  ex_imm,
    output logic [SHAMT_WIDTH-1:0] ex_shamt
);

    logic      ir_valid;
    word_t     ir_instr;
    ex_ctrl_t  dec_ctrl;
    imm_ext_t  dec_imm_ext;
    logic      dec_reg_w;
    reg_addr_t dec_rd_addr;
    word_t     imm_full;

    //////////////////////////////////////////////////
    // Instruction register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            ir_valid <= 1'b0;
        end else begin
            ir_valid <= instr_valid;
        end
        if (instr_valid) begin
            ir_instr <= instr;
        end
    end

    decoder decoder (
        .instr   ( ir_instr    ),
        .ctrl    ( dec_ctrl    ),
        .imm_ext ( dec_imm_ext ),
        .reg_w   ( dec_reg_w   ),
        .rd_addr ( dec_rd_addr )
    );

    assign rs_addr = ir_instr[RS_LSB +: 5];
    assign rt_addr = ir_instr[RT_LSB +: 5];

    // Immediate extension
    assign imm_full = (dec_imm_ext == EXT_SIGN)
        ? {{(32 - IMM_WIDTH){ir_instr[IMM_WIDTH-1]}}, ir_instr[IMM_WIDTH-1:0]}
        : {{(32 - IMM_WIDTH){1'b0}}, ir_instr[IMM_WIDTH-1:0]};

    //////////////////////////////////////////////////
    // Decode to execute register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
            ex_reg_w <= 1'b0;
        end else begin
            ex_valid <= ir_valid;
            ex_reg_w <= ir_valid && dec_reg_w;
        end
        ex_ctrl    <= dec_ctrl;
        ex_rs_addr <= rs_addr;
        ex_rt_addr <= rt_addr;
        ex_rd_addr <= dec_rd_addr;
        ex_op_a    <= rs_data;
        ex_op_b    <= rt_data;
        ex_imm     <= imm_full;
        ex_shamt   <= ir_instr[SHAMT_LSB +: SHAMT_WIDTH];
    end

    a_valid_known: assert property (
        @(posedge clk) disable iff (reset) !$isunknown(instr_valid)
    );

endmodule

// File: decode/decoder.sv
module decoder
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  word_t     instr,
    output ex_ctrl_t  ctrl,
    output imm_ext_t  imm_ext,
    output logic      reg_w,
    output reg_addr_t rd_addr
);

    opcode_t opcode;
    funct_t  funct;
    logic    supported;

    assign opcode = opcode_t'(instr[OPCODE_LSB +: 6]);
    assign funct  = funct_t'(instr[FUNCT_LSB +: 6]);

    always_comb begin
        ctrl.alu_op         = ALU_ADD;
        ctrl.shift_op       = SHIFT_SLL;
        ctrl.b_is_imm       = 1'b0;
        ctrl.shamt_from_reg = 1'b0;
        ctrl.res_sel        = RES_ALU;
        imm_ext             = EXT_SIGN;
        supported           = 1'b1;
        // Immediate forms write rt, register forms write rd
        rd_addr             = instr[RT_LSB +: 5];

        case (opcode)
            OP_SPECIAL: begin
                rd_addr = instr[RD_LSB +: 5];
                case (funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_XOR:  ctrl.alu_op = ALU_XOR;
                    FN_NOR:  ctrl.alu_op = ALU_NOR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_SLTU: ctrl.alu_op = ALU_SLTU;
                    FN_SLL, FN_SLLV: begin
                        ctrl.res_sel        = RES_SHIFT;
                        ctrl.shift_op       = SHIFT_SLL;
                        ctrl.shamt_from_reg = (funct == FN_SLLV);
                    end
                    FN_SRL, FN_SRLV: begin
                        ctrl.res_sel        = RES_SHIFT;
                        ctrl.shift_op       = SHIFT_SRL;
                        ctrl.shamt_from_reg = (funct == FN_SRLV);
                    end
                    FN_SRA, FN_SRAV: begin
                        ctrl.res_sel        = RES_SHIFT;
                        ctrl.shift_op       = SHIFT_SRA;
                        ctrl.shamt_from_reg = (funct == FN_SRAV);
                    end
                    default: supported = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                ctrl.b_is_imm = 1'b1;
                ctrl.alu_op   = ALU_ADD;
            end
            OP_SLTI: begin
                ctrl.b_is_imm = 1'b1;
                ctrl.alu_op   = ALU_SLT;
            end
            // sltiu still sign extends, then compares unsigned
            OP_SLTIU: begin
                ctrl.b_is_imm = 1'b1;
                ctrl.alu_op   = ALU_SLTU;
            end
            OP_ANDI: begin
                ctrl.b_is_imm = 1'b1;
                ctrl.alu_op   = ALU_AND;
                imm_ext       = EXT_ZERO;
            end
            OP_ORI: begin
                ctrl.b_is_imm = 1'b1;
                ctrl.alu_op   = ALU_OR;
                imm_ext       = EXT_ZERO;
            end
            OP_XORI: begin
                ctrl.b_is_imm = 1'b1;
                ctrl.alu_op   = ALU_XOR;
                imm_ext       = EXT_ZERO;
            end
            OP_LUI: begin
                ctrl.b_is_imm = 1'b1;
                ctrl.alu_op   = ALU_LUI;
                imm_ext       = EXT_ZERO;
            end
            default: supported = 1'b0;
        endcase

        // $0 is hardwired, so a write there is dropped here
        reg_w = supported && (rd_addr != '0);
    end

endmodule

// File: decode/regfile.sv
module regfile
    import isa_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  reg_addr_t wr_addr,
    input  logic      wr_en,
    input  word_t     wr_data,
    output word_t     rs_data,
    output word_t     rt_data
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // A read in the writeback cycle sees the new write data
    assign rs_data = (wr_en && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
    assign rt_data = (wr_en && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

    // Decoder must have filtered out every write to $0
    a_no_write_r0: assert property (
        @(posedge clk) disable iff (reset) wr_en |-> (wr_addr != '0)
    );

endmodule

// File: execute/alu.sv
module alu
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   result
);

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_NOR:  result = ~(a | b);
            // Compares give 0 or 1
            ALU_SLT:  result = {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'd0, a < b};
            // Immediate moves to the upper half
            ALU_LUI:  result = {b[15:0], 16'd0};
            default:  result = '0;
        endcase
    end

endmodule

// File: execute/execute_stage.sv
module execute_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ex_valid,
    input  logic                   ex_reg_w,
    input  ex_ctrl_t               ex_ctrl,
    input  reg_addr_t              ex_rs_addr,
    input  reg_addr_t              ex_rt_addr,
    input  reg_addr_t              ex_rd_addr,
    input  word_t                  ex_op_a,
    input  word_t                  ex_op_b,
    input  word_t                  ex_imm,
    input  logic [SHAMT_WIDTH-1:0] ex_shamt,
    output logic                   wb_reg_w,
    output reg_addr_t              wb_rd_addr,
    output word_t                  wb_data
);

    word_t                  fwd_a;
    word_t                  fwd_b;
    word_t                  alu_b;
    word_t                  alu_out;
    word_t                  shift_out;
    word_t                  exec_result;
    logic [SHAMT_WIDTH-1:0] shamt_sel;

    //////////////////////////////////////////////////
    // Forwarding from the writeback register
    //////////////////////////////////////////////////

    assign fwd_a = (wb_reg_w && wb_rd_addr == ex_rs_addr) ? wb_data : ex_op_a;
    assign fwd_b = (wb_reg_w && wb_rd_addr == ex_rt_addr) ? wb_data : ex_op_b;

    // Operand B and shift amount selection
    assign alu_b     = ex_ctrl.b_is_imm ? ex_imm : fwd_b;
    assign shamt_sel = ex_ctrl.shamt_from_reg ? fwd_a[SHAMT_WIDTH-1:0] : ex_shamt;

    alu alu (
        .a      ( fwd_a          ),
        .b      ( alu_b          ),
        .op     ( ex_ctrl.alu_op ),
        .result ( alu_out        )
    );

    // Shifter always works on rt
    always_comb begin
        case (ex_ctrl.shift_op)
            SHIFT_SLL: shift_out = fwd_b << shamt_sel;
            SHIFT_SRL: shift_out = fwd_b >> shamt_sel;
            SHIFT_SRA: shift_out = word_t'($signed(fwd_b) >>> shamt_sel);
            default:   shift_out = fwd_b;
        endcase
    end

    assign exec_result = (ex_ctrl.res_sel == RES_SHIFT) ? shift_out : alu_out;

    //////////////////////////////////////////////////
    // Execute to writeback register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_reg_w <= 1'b0;
        end else begin
            wb_reg_w <= ex_valid && ex_reg_w;
        end
        wb_rd_addr <= ex_rd_addr;
        wb_data    <= exec_result;
    end

    // $0 writes are suppressed back in decode
    a_wb_not_r0: assert property (
        @(posedge clk) disable iff (reset) wb_reg_w |-> (wb_rd_addr != '0)
    );

endmodule

// File: hdl/pipeline.sv
module pipeline
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      instr_valid,
    input  word_t     instr,
    output logic      wb_valid,
    output reg_addr_t wb_rd_addr,
    output word_t     wb_data
);

    reg_addr_t              rs_addr;
    reg_addr_t              rt_addr;
    word_t                  rs_data;
    word_t                  rt_data;
    logic                   ex_valid;
    logic                   ex_reg_w;
    ex_ctrl_t               ex_ctrl;
    reg_addr_t              ex_rs_addr;
    reg_addr_t              ex_rt_addr;
    reg_addr_t              ex_rd_addr;
    word_t                  ex_op_a;
    word_t                  ex_op_b;
    word_t                  ex_imm;
    logic [SHAMT_WIDTH-1:0] ex_shamt;

    decode_stage decode_stage (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .instr_valid ( instr_valid ),
        .instr       ( instr       ),
        .rs_addr     ( rs_addr     ),
        .rt_addr     ( rt_addr     ),
        .rs_data     ( rs_data     ),
        .rt_data     ( rt_data     ),
        .ex_valid    ( ex_valid    ),
        .ex_reg_w    ( ex_reg_w    ),
        .ex_ctrl     ( ex_ctrl     ),
        .ex_rs_addr  ( ex_rs_addr  ),
        .ex_rt_addr  ( ex_rt_addr  ),
        .ex_rd_addr  ( ex_rd_addr  ),
        .ex_op_a     ( ex_op_a     ),
        .ex_op_b     ( ex_op_b     ),
        .ex_imm      ( ex_imm      ),
        .ex_shamt    ( ex_shamt    )
    );

    // Writeback register drives the file write port directly
    regfile gpr (
        .clk     ( clk        ),
        .reset   ( reset      ),
        .rs_addr ( rs_addr    ),
        .rt_addr ( rt_addr    ),
        .wr_addr ( wb_rd_addr ),
        .wr_en   ( wb_valid   ),
        .wr_data ( wb_data    ),
        .rs_data ( rs_data    ),
        .rt_data ( rt_data    )
    );

    execute_stage execute_stage (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .ex_valid   ( ex_valid   ),
        .ex_reg_w   ( ex_reg_w   ),
        .ex_ctrl    ( ex_ctrl    ),
        .ex_rs_addr ( ex_rs_addr ),
        .ex_rt_addr ( ex_rt_addr ),
        .ex_rd_addr ( ex_rd_addr ),
        .ex_op_a    ( ex_op_a    ),
        .ex_op_b    ( ex_op_b    ),
        .ex_imm     ( ex_imm     ),
        .ex_shamt   ( ex_shamt   ),
        .wb_reg_w   ( wb_valid   ),
        .wb_rd_addr ( wb_rd_addr ),
        .wb_data    ( wb_data    )
    );

endmodule

// File: sim.f
+incdir+bench
common/isa_pkg.sv
common/pipe_pkg.sv
decode/decoder.sv
decode/regfile.sv
decode/decode_stage.sv
execute/alu.sv
execute/execute_stage.sv
hdl/pipeline.sv
bench/tb_pipeline.sv
